// File: src.f
src/fetch_pkg.sv
src/prefetch_controller.sv
src/prefetch_fifo.sv
src/decode_stage.sv
src/perf_counters.sv
src/fetch_wrapper.sv
bench/fetch_properties.sv
bench/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "FAIL: see errors above" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fetch_tb.sv
// **************************************************
// Fetch front end testbench
// Memory model, reference decode and directed tests
// **************************************************
`timescale 1ns/10ps

module fetch_tb;

  localparam int DEPTH      = 4;
  localparam int WAIT_LIMIT = 4000;

  logic                             clk_i, arst_n_i, fetch_enable_i;
  logic                             instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [fetch_pkg::ADDR_W-1:0]     boot_addr_i, instr_addr_o;
  logic [fetch_pkg::INSTR_W-1:0]    instr_rdata_i;
  logic                             dec_valid_o, dec_ready_i;
  fetch_pkg::decode_t               dec_o;
  logic [3:0][fetch_pkg::CNT_W-1:0] counters_o;

  // Memory table with per-address error flag, and the in-order grant queue
  logic [31:0]                 mem_word [logic [31:0]];
  bit                          mem_err [logic [31:0]];
  logic [31:0]                 pend_addr [$];
  int                          pend_due [$];
  int                          errors, retired, granted, cyc, ready_mode, stretch_left;
  bit                          abort, ready_level;
  logic [31:0]                 exp_pc;
  logic [fetch_pkg::CNT_W-1:0] cnt_total, cnt_ill, cnt_mem, cnt_ctrl;

  fetch_wrapper fetch_wrapper_i (.*);

  always #20 clk_i = ~clk_i;

  // Addresses never written read a pattern mixed from the whole address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return mem_word.exists(addr) ? mem_word[addr] : (addr * 32'h9E3779B1) ^ ~addr;
  endfunction

  function automatic bit err_at(input logic [31:0] addr);
    return mem_err.exists(addr) ? mem_err[addr] : 1'b0;
  endfunction

  function automatic fetch_pkg::decode_t expected_record(input logic [31:0] pc);
    fetch_pkg::decode_t rec;
    rec.pc    = pc;
    rec.instr = word_at(pc);
    if (err_at(pc) || rec.instr[1:0] != 2'b11) begin
      rec.iclass = fetch_pkg::ILLEGAL;
    end else begin
      case (rec.instr[6:0])
        fetch_pkg::LOAD, fetch_pkg::STORE: rec.iclass = fetch_pkg::MEM;
        fetch_pkg::BRANCH, fetch_pkg::JAL, fetch_pkg::JALR: rec.iclass = fetch_pkg::CTRL;
        fetch_pkg::SYSTEM: rec.iclass = fetch_pkg::SYS;
        fetch_pkg::OP_IMM, fetch_pkg::OP, fetch_pkg::LUI, fetch_pkg::AUIPC:
          rec.iclass = fetch_pkg::ALU;
        default: rec.iclass = fetch_pkg::ILLEGAL;
      endcase
    end
    return rec;
  endfunction

  task automatic compare_decode(input string name, input fetch_pkg::decode_t exp_rec,
                                input fetch_pkg::decode_t act_rec);
    if (act_rec !== exp_rec) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp_rec, act_rec);
    end
  endtask

  task automatic compare_counter(input string name, input logic [fetch_pkg::CNT_W-1:0] exp_val,
                                 input logic [fetch_pkg::CNT_W-1:0] act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
    end
  endtask

  // Memory grants at random and answers in grant order after 0 to 2 cycles
  always begin
    int rnd;
    @(posedge clk_i);
    cyc++;
    if (arst_n_i && instr_req_o && instr_gnt_i) begin
      pend_addr.push_back(instr_addr_o);
      pend_due.push_back(cyc + int'($urandom % 3));
      granted++;
    end
    @(negedge clk_i);
    instr_gnt_i    = ($urandom % 3) != 0;
    instr_rvalid_i = 1'b0;
    instr_err_i    = 1'b0;
    if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = word_at(pend_addr[0]);
      instr_err_i    = err_at(pend_addr[0]);
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    // FIFO, slot and requests in flight bound what fetch may run ahead
    if (granted - retired > DEPTH + 1) begin
      errors++;
      $display("Fetch ran ahead of decode by %0d words", granted - retired);
    end
    rnd = int'($urandom % 4);
    if (stretch_left == 0) begin
      ready_level  = !ready_level;
      stretch_left = ready_level ? 1 + int'($urandom % 6) : 4 + int'($urandom % 24);
    end else begin
      stretch_left--;
    end
    case (ready_mode)
      1:       dec_ready_i = (rnd != 0);
      2:       dec_ready_i = ready_level;
      default: dec_ready_i = 1'b1;
    endcase
  end

  // Each transfer is checked in pc order and counted by its class
  always @(posedge clk_i) begin : monitor
    fetch_pkg::decode_t exp_rec;
    if (arst_n_i && dec_valid_o && dec_ready_i) begin
      exp_rec = expected_record(exp_pc);
      compare_decode("dec_o", exp_rec, dec_o);
      cnt_total = cnt_total + 1'b1;
      if (exp_rec.iclass == fetch_pkg::ILLEGAL) cnt_ill = cnt_ill + 1'b1;
      if (exp_rec.iclass == fetch_pkg::MEM) cnt_mem = cnt_mem + 1'b1;
      if (exp_rec.iclass == fetch_pkg::CTRL) cnt_ctrl = cnt_ctrl + 1'b1;
      exp_pc = exp_pc + 32'd4;
      retired++;
    end
  end

  // With drain set, waits until every granted word is out and req is low
  task automatic wait_for(input int target, input bit drain);
    int n;
    n = 0;
    while (!abort && (drain ? (granted != retired || instr_req_o) : retired < target)) begin
      if (n == WAIT_LIMIT) begin
        errors++;
        abort = 1'b1;
        $display("Timeout after %0d cycles with %0d words granted and %0d records out",
                 n, granted, retired);
      end else begin
        @(negedge clk_i);
        n++;
      end
    end
  endtask

  task automatic check_counters();
    compare_counter("counters_o[0]", cnt_total, counters_o[0]);
    compare_counter("counters_o[1]", cnt_ill, counters_o[1]);
    compare_counter("counters_o[2]", cnt_mem, counters_o[2]);
    compare_counter("counters_o[3]", cnt_ctrl, counters_o[3]);
  endtask

  // Fetch from boot until n records are out, then stop and drain
  task automatic run_block(input logic [31:0] boot, input int n);
    @(negedge clk_i);
    exp_pc         = boot;
    boot_addr_i    = boot;
    fetch_enable_i = 1'b1;
    wait_for(retired + n, 1'b0);
    @(negedge clk_i);
    fetch_enable_i = 1'b0;
    wait_for(0, 1'b1);
    repeat (2) @(negedge clk_i);
    check_counters();
  endtask

  task automatic test_sequential();
    for (int i = 0; i < 24; i++) mem_word[32'h1000 + 4 * i] = $urandom;
    run_block(32'h0000_1000, 24);
  endtask

  task automatic test_classes();
    logic [6:0]  ops [13];
    logic [31:0] w;
    ops = '{fetch_pkg::LOAD, fetch_pkg::STORE, fetch_pkg::OP_IMM, fetch_pkg::OP,
            fetch_pkg::LUI, fetch_pkg::AUIPC, fetch_pkg::BRANCH, fetch_pkg::JAL,
            fetch_pkg::JALR, fetch_pkg::SYSTEM, 7'b0001011, 7'b0101111, 7'b1111111};
    for (int i = 0; i < 13; i++) begin
      w      = $urandom;
      w[6:0] = ops[i];
      mem_word[32'h2000 + 4 * i] = w;
    end
    run_block(32'h0000_2000, 13);
  endtask

  // Bad low bits on an OP word, or a bus error on an intact one
  task automatic test_illegal();
    logic [31:0] w;
    for (int i = 0; i < 12; i++) begin
      w      = $urandom;
      w[6:0] = fetch_pkg::OP;
      if (i % 4 == 3) mem_err[32'h3000 + 4 * i] = 1'b1;
      else w[1:0] = 2'(i % 4);
      mem_word[32'h3000 + 4 * i] = w;
    end
    run_block(32'h0000_3000, 12);
  endtask

  task automatic test_backpressure();
    for (int i = 0; i < 64; i++) mem_word[32'h4000 + 4 * i] = $urandom;
    ready_mode = 2;
    run_block(32'h0000_4000, 40);
    ready_mode = 1;
    run_block(32'h0000_4000, 24);
    ready_mode = 0;
  endtask

  task automatic test_restart();
    int g;
    run_block(32'h0000_5000, 6);
    g = granted;
    repeat (10) @(negedge clk_i);
    if (granted != g || instr_req_o) begin
      errors++;
      $display("Requests continued after fetch_enable_i was cleared");
    end
    run_block(32'h0000_5000, 6);
  endtask

  initial begin
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    dec_ready_i    = 1'b1;
    cnt_total      = '0;
    cnt_ill        = '0;
    cnt_mem        = '0;
    cnt_ctrl       = '0;
    void'($urandom(16));
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;
    check_counters();
    test_sequential();
    if (!abort) test_classes();
    if (!abort) test_illegal();
    if (!abort) test_backpressure();
    if (!abort) test_restart();
    errors += fetch_wrapper_i.fetch_properties_i.fail_count;
    $display("Summary: %0d errors, %0d records checked, %0d assertion failures",
             errors, retired, fetch_wrapper_i.fetch_properties_i.fail_count);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: bench/fetch_properties.sv
// **************************************************
// Fetch front end properties
// Request hold, credit limit and output hold checks
// **************************************************
`timescale 1ns/10ps

module fetch_properties #(
  parameter int DEPTH = 4
) (
  input logic                         clk_i,
  input logic                         arst_n_i,
  input logic                         req_i,
  input logic                         gnt_i,
  input logic [fetch_pkg::ADDR_W-1:0] addr_i,
  input logic [$clog2(DEPTH+1)-1:0]   outstanding_i,
  input logic [$clog2(DEPTH+1)-1:0]   fifo_count_i,
  input logic                         dec_valid_i,
  input logic                         dec_ready_i,
  input fetch_pkg::decode_t           dec_i
);

  int fail_count = 0;

  // An ungranted request stays up with the same address
  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i && !gnt_i |=> req_i && $stable(addr_i))
    else begin
      fail_count++;
      $error("instr_req_o or instr_addr_o changed before grant");
    end

  // Words in flight plus buffered words never exceed the FIFO depth
  a_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    int'(outstanding_i) + int'(fifo_count_i) <= DEPTH)
    else begin
      fail_count++;
      $error("outstanding requests plus FIFO count exceed DEPTH");
    end

  a_dec_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dec_valid_i && !dec_ready_i |=> dec_valid_i && $stable(dec_i))
    else begin
      fail_count++;
      $error("dec_o changed while stalled");
    end

endmodule

bind fetch_wrapper fetch_properties #(
  .DEPTH ( DEPTH )
) fetch_properties_i (
  .clk_i         ( clk_i                               ),
  .arst_n_i      ( arst_n_i                            ),
  .req_i         ( instr_req_o                         ),
  .gnt_i         ( instr_gnt_i                         ),
  .addr_i        ( instr_addr_o                        ),
  .outstanding_i ( prefetch_controller_i.outstanding_q ),
  .fifo_count_i  ( fifo_count                          ),
  .dec_valid_i   ( dec_valid_o                         ),
  .dec_ready_i   ( dec_ready_i                         ),
  .dec_i         ( dec_o                               )
);

// File: src/fetch_wrapper.sv
// **************************************************
// Fetch wrapper
// Prefetch, FIFO, decode and counters joined up
// **************************************************
`timescale 1ns/10ps

module fetch_wrapper #(
  parameter int DEPTH            = 4,
  parameter int NUM_MHPMCOUNTERS = 4
) (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  input  logic                                              fetch_enable_i,
  input  logic [fetch_pkg::ADDR_W-1:0]                      boot_addr_i,

  // Instruction memory interface
  output logic                                              instr_req_o,
  input  logic                                              instr_gnt_i,
  input  logic                                              instr_rvalid_i,
  output logic [fetch_pkg::ADDR_W-1:0]                      instr_addr_o,
  input  logic [fetch_pkg::INSTR_W-1:0]                     instr_rdata_i,
  input  logic                                              instr_err_i,

  // Decode output
  output logic                                              dec_valid_o,
  output fetch_pkg::decode_t                                dec_o,
  input  logic                                              dec_ready_i,

  output logic [NUM_MHPMCOUNTERS-1:0][fetch_pkg::CNT_W-1:0] counters_o
);

  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic                  push;
  fetch_pkg::fetch_rsp_t push_data;
  fetch_pkg::fetch_rsp_t fifo_head;
  logic                  fifo_empty;
  logic                  fifo_pop;
  logic [CNT_BITS-1:0]   fifo_count;
  logic                  retire;
  fetch_pkg::iclass_e    retire_class;

  prefetch_controller #(
    .DEPTH ( DEPTH )
  ) prefetch_controller_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_err_i    ( instr_err_i    ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fifo_count_i   ( fifo_count     ),
    .push_o         ( push           ),
    .push_data_o    ( push_data      )
  );

  prefetch_fifo #(
    .DEPTH ( DEPTH )
  ) prefetch_fifo_i (
    .clk_i       ( clk_i      ),
    .arst_n_i    ( arst_n_i   ),
    .push_i      ( push       ),
    .push_data_i ( push_data  ),
    .pop_i       ( fifo_pop   ),
    .head_o      ( fifo_head  ),
    .empty_o     ( fifo_empty ),
    .count_o     ( fifo_count )
  );

  decode_stage decode_stage_i (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .fifo_empty_i   ( fifo_empty   ),
    .fifo_head_i    ( fifo_head    ),
    .fifo_pop_o     ( fifo_pop     ),
    .dec_valid_o    ( dec_valid_o  ),
    .dec_o          ( dec_o        ),
    .dec_ready_i    ( dec_ready_i  ),
    .retire_o       ( retire       ),
    .retire_class_o ( retire_class )
  );

  perf_counters #(
    .NUM_MHPMCOUNTERS ( NUM_MHPMCOUNTERS )
  ) perf_counters_i (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .retire_i       ( retire       ),
    .retire_class_i ( retire_class ),
    .counters_o     ( counters_o   )
  );

endmodule

// File: src/perf_counters.sv
// **************************************************
// Performance counters
// Retired, illegal, memory and control-flow counts
// **************************************************
`timescale 1ns/10ps

module perf_counters #(
  parameter int NUM_MHPMCOUNTERS = 4
) (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  logic                                           retire_i,
  input  fetch_pkg::iclass_e                             retire_class_i,
  output logic [NUM_MHPMCOUNTERS-1:0][fetch_pkg::CNT_W-1:0] counters_o
);

  // Event selected by each counter index
  function automatic logic event_hit(
    input int                 idx,
    input logic               retire,
    input fetch_pkg::iclass_e cls
  );
    logic hit;
    case (idx)
      0:       hit = retire;
      1:       hit = retire && (cls == fetch_pkg::ILLEGAL);
      2:       hit = retire && (cls == fetch_pkg::MEM);
      3:       hit = retire && (cls == fetch_pkg::CTRL);
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

  // Only the configured counters exist; each wraps at CNT_W bits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      counters_o <= '0;
    end else begin
      for (int i = 0; i < NUM_MHPMCOUNTERS; i++) begin
        if (event_hit(i, retire_i, retire_class_i)) begin
          counters_o[i] <= counters_o[i] + 1'b1;
        end
      end
    end
  end

endmodule

// File: src/decode_stage.sv
// **************************************************
// Decode stage
// Classifies fetched words into a held decode record
// **************************************************
`timescale 1ns/10ps

module decode_stage (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  fifo_empty_i,
  input  fetch_pkg::fetch_rsp_t fifo_head_i,
  output logic                  fifo_pop_o,
  output logic                  dec_valid_o,
  output fetch_pkg::decode_t    dec_o,
  input  logic                  dec_ready_i,
  output logic                  retire_o,
  output fetch_pkg::iclass_e    retire_class_o
);

  fetch_pkg::decode_t rec_d;
  logic               slot_free;

  // Major opcode to class, with bus errors and bad low bits as illegal
  function automatic fetch_pkg::iclass_e classify(
    input logic [fetch_pkg::INSTR_W-1:0] word,
    input logic                          err
  );
    fetch_pkg::iclass_e cls;
    case (word[6:0])
      fetch_pkg::OP_IMM,
      fetch_pkg::OP,
      fetch_pkg::LUI,
      fetch_pkg::AUIPC:  cls = fetch_pkg::ALU;
      fetch_pkg::LOAD,
      fetch_pkg::STORE:  cls = fetch_pkg::MEM;
      fetch_pkg::BRANCH,
      fetch_pkg::JAL,
      fetch_pkg::JALR:   cls = fetch_pkg::CTRL;
      fetch_pkg::SYSTEM: cls = fetch_pkg::SYS;
      default:           cls = fetch_pkg::ILLEGAL;
    endcase
    if (err || (word[1:0] != 2'b11)) cls = fetch_pkg::ILLEGAL;
    return cls;
  endfunction

  always_comb begin
    rec_d.pc     = fifo_head_i.addr;
    rec_d.instr  = fifo_head_i.rdata;
    rec_d.iclass = classify(fifo_head_i.rdata, fifo_head_i.err);
  end

  // Slot can take a new record when empty or when it drains this cycle
  assign slot_free  = !dec_valid_o || dec_ready_i;
  assign fifo_pop_o = !fifo_empty_i && slot_free;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_o <= 1'b0;
    end else if (fifo_pop_o) begin
      dec_valid_o <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  // Record only loads on pop, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) dec_o <= rec_d;
  end

  // One pulse per transferred record
  assign retire_o       = dec_valid_o && dec_ready_i;
  assign retire_class_o = dec_o.iclass;

endmodule

// File: src/prefetch_fifo.sv
// **************************************************
// Prefetch FIFO
// Circular buffer of fetch responses with count
// **************************************************
`timescale 1ns/10ps

module prefetch_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       push_i,
  input  fetch_pkg::fetch_rsp_t      push_data_i,
  input  logic                       pop_i,
  output fetch_pkg::fetch_rsp_t      head_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  fetch_pkg::fetch_rsp_t mem_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_BITS-1:0]   count_q;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  // Pointers wrap at DEPTH-1, so DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count_q == CNT_BITS'(DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  assign head_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);

      // Simultaneous push and pop leaves the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: src/prefetch_controller.sv
// **************************************************
// Prefetch controller
// Sequential word requests under a FIFO credit limit
// **************************************************
`timescale 1ns/10ps

module prefetch_controller #(
  parameter int DEPTH = 4
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          fetch_enable_i,
  input  logic [fetch_pkg::ADDR_W-1:0]  boot_addr_i,
  output logic                          instr_req_o,
  output logic [fetch_pkg::ADDR_W-1:0]  instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  logic                          instr_err_i,
  input  logic [fetch_pkg::INSTR_W-1:0] instr_rdata_i,
  input  logic [$clog2(DEPTH+1)-1:0]    fifo_count_i,
  output logic                          push_o,
  output fetch_pkg::fetch_rsp_t         push_data_o
);

  localparam int CNT_BITS = $clog2(DEPTH + 1);
  localparam logic [fetch_pkg::ADDR_W-1:0] WORD_STEP = 'd4;

  fetch_pkg::pf_state_e         state_q;
  fetch_pkg::pf_state_e         state_d;
  logic [fetch_pkg::ADDR_W-1:0] req_addr_q;
  logic [fetch_pkg::ADDR_W-1:0] rsp_addr_q;
  logic [CNT_BITS-1:0]          outstanding_q;
  logic [CNT_BITS:0]            credit_used;
  logic                         credit_ok;
  logic                         req_hold_q;
  logic                         start;
  logic                         accept;

  // Words in flight plus words buffered must stay below DEPTH
  assign credit_used = {1'b0, outstanding_q} + {1'b0, fifo_count_i};
  assign credit_ok   = credit_used < (CNT_BITS + 1)'(DEPTH);

  assign start  = (state_q == fetch_pkg::IDLE) && fetch_enable_i;

  // A raised request stays up until granted, even after enable drops
  assign instr_req_o  = req_hold_q ||
                        ((state_q == fetch_pkg::FETCH) && fetch_enable_i && credit_ok);
  assign instr_addr_o = req_addr_q;
  assign accept       = instr_req_o && instr_gnt_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::IDLE:  if (fetch_enable_i) state_d = fetch_pkg::FETCH;
      fetch_pkg::FETCH: if (!fetch_enable_i) state_d = fetch_pkg::DRAIN;
      fetch_pkg::DRAIN: begin
        if ((outstanding_q == '0) && !req_hold_q) state_d = fetch_pkg::IDLE;
      end
      default: state_d = fetch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= fetch_pkg::IDLE;
      req_hold_q    <= 1'b0;
      outstanding_q <= '0;
      req_addr_q    <= '0;
      rsp_addr_q    <= '0;
    end else begin
      state_q    <= state_d;
      req_hold_q <= instr_req_o && !instr_gnt_i;

      case ({accept, instr_rvalid_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase

      // Request and response addresses walk separately
      if (start) begin
        req_addr_q <= boot_addr_i;
        rsp_addr_q <= boot_addr_i;
      end else begin
        if (accept) req_addr_q <= req_addr_q + WORD_STEP;
        if (instr_rvalid_i) rsp_addr_q <= rsp_addr_q + WORD_STEP;
      end
    end
  end

  // Responses return in order, so rsp_addr_q tags each word
  always_comb begin
    push_o            = instr_rvalid_i;
    push_data_o.addr  = rsp_addr_q;
    push_data_o.rdata = instr_rdata_i;
    push_data_o.err   = instr_err_i;
  end

endmodule

// File: src/fetch_pkg.sv
// **************************************************
// Fetch package
// Widths, opcode and class enums, shared structs
// **************************************************

package fetch_pkg;

  // Datapath widths
  localparam int ADDR_W  = 32;
  localparam int INSTR_W = 32;
  localparam int CNT_W   = 16;

  // RV32 major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    SYSTEM = 7'b1110011
  } opcode_e;

  // Instruction class seen by decode and the counters
  typedef enum logic [2:0] {
    ALU,
    MEM,
    CTRL,
    SYS,
    ILLEGAL
  } iclass_e;

  // Prefetch controller states
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    DRAIN
  } pf_state_e;

  // One returned word tagged with its address, 65 bits
  typedef struct packed {
    logic [ADDR_W-1:0]  addr;
    logic [INSTR_W-1:0] rdata;
    logic               err;
  } fetch_rsp_t;

  // Decode record handed downstream, 67 bits
  typedef struct packed {
    logic [ADDR_W-1:0]  pc;
    logic [INSTR_W-1:0] instr;
    iclass_e            iclass;
  } decode_t;

endpackage
